//--- sys1_input_pkg.sv
// Arcade input subsystem shared definitions
// Widths, download indices, mode-bit positions and the joystick word layout
`default_nettype none

package sys1_input_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int unsigned joy_w        = 16;
	localparam int unsigned llapi_btn_w  = 32;
	localparam int unsigned llapi_type_w = 8;
	localparam int unsigned num_ports    = 2;

	// Download index targets
	localparam logic [7:0] idx_sysmode = 8'd1;
	localparam logic [7:0] idx_dsw     = 8'd254;

	// System-mode byte, water match style control layout
	localparam int unsigned sysmode_twin_bit = 3;

	// 10 s at 48 MHz
	localparam int unsigned dim_cycles_default = 480_000_000;

	////////////////////////////////////////////////////////////
	// Joystick word, one 16-bit vector with two readings
	////////////////////////////////////////////////////////////
	typedef union packed {
		// Standard panel view
		struct packed {
			logic [2:0] unused;
			logic       pause;
			logic       coin;
			logic       start2;
			logic       start1;
			logic [5:1] trig;
			logic       up;
			logic       down;
			logic       left;
			logic       right;
		} stnd;
		// Twin-stick view, start/coin/pause keep their places
		struct packed {
			logic [2:0] unused;
			logic       pause;
			logic       coin;
			logic       start2;
			logic       start1;
			logic       fire;
			logic       r_up;
			logic       r_down;
			logic       r_left;
			logic       r_right;
			logic       l_up;
			logic       l_down;
			logic       l_left;
			logic       l_right;
		} twin;
	} joy_word_u;

endpackage

`default_nettype wire

//--- sys_config.sv
// Cabinet configuration download
// Catches system-mode and DIP bytes from the download stream
`timescale 1ns/1ns
`default_nettype none

module sys_config (
	input  logic        clk_sys,
	input  logic        iRST,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic        llapi_select,
	output logic [7:0]  sysmode,
	output logic [7:0]  dsw0,
	output logic [7:0]  dsw1,
	output logic        llapi_on
);

	logic sel_sysmode;
	logic sel_dsw0;
	logic sel_dsw1;

	// Address decode, only the low DIP bytes are kept
	assign sel_sysmode = (ioctl_index == sys1_input_pkg::idx_sysmode) && (ioctl_addr == 25'd0);
	assign sel_dsw0    = (ioctl_index == sys1_input_pkg::idx_dsw) && (ioctl_addr == 25'd0);
	assign sel_dsw1    = (ioctl_index == sys1_input_pkg::idx_dsw) && (ioctl_addr == 25'd1);

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			sysmode <= 8'h00;
			dsw0    <= 8'h00;
			dsw1    <= 8'h00;
		end else if (ioctl_wr) begin
			// Each byte lands one clock after its strobe
			if (sel_sysmode)
				sysmode <= ioctl_dout;
			if (sel_dsw0)
				dsw0 <= ioctl_dout;
			if (sel_dsw1)
				dsw1 <= ioctl_dout;
		end
	end

	// OSD low-latency enable, retimed into the core domain
	always_ff @(posedge clk_sys) begin
		if (iRST)
			llapi_on <= 1'b0;
		else
			llapi_on <= llapi_select;
	end

endmodule

`default_nettype wire

//--- llapi_port_map.sv
// Low-latency controller port mapper
// Presence check, button remap to the joystick word and OSD combo detect
`timescale 1ns/1ns
`default_nettype none

module llapi_port_map (
	input  logic                                     clk_sys,
	input  logic                                     iRST,
	input  logic                                     llapi_on,
	input  logic [sys1_input_pkg::llapi_btn_w-1:0]   buttons,
	input  logic [sys1_input_pkg::llapi_type_w-1:0]  ctrl_type,
	input  logic                                     ctrl_en,
	output sys1_input_pkg::joy_word_u                joy_word,
	output logic                                     use_port,
	output logic                                     osd_combo
);

	logic btn_seen;
	logic any_btn;
	logic type_valid;
	logic use_next;
	logic combo_held;
	sys1_input_pkg::joy_word_u joy_next;

	////////////////////////////////////////////////////////////
	// Presence
	////////////////////////////////////////////////////////////
	assign any_btn = |buttons;

	// Type 0 is no pad or an Atari pad, 255 is a floating line
	assign type_valid = (|ctrl_type) && !(&ctrl_type);

	// Current press counts too, so the first press claims the slot at once
	assign use_next = llapi_on && ctrl_en && (type_valid || btn_seen || any_btn);

	// Sticky until reset
	always_ff @(posedge clk_sys) begin
		if (iRST)
			btn_seen <= 1'b0;
		else if (any_btn)
			btn_seen <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Button remap
	////////////////////////////////////////////////////////////
	always_comb begin
		joy_next = '0;
		// D-pad sits in the top byte of the pad report
		joy_next.stnd.right  = buttons[24];
		joy_next.stnd.left   = buttons[25];
		joy_next.stnd.down   = buttons[26];
		joy_next.stnd.up     = buttons[27];
		joy_next.stnd.trig   = {buttons[6], buttons[3], buttons[2], buttons[1], buttons[0]};
		joy_next.stnd.start1 = buttons[5];
		joy_next.stnd.coin   = buttons[4];
		// start2 and pause stay 0
	end

	// Down + start + first button opens the OSD
	assign combo_held = buttons[26] && buttons[5] && buttons[0];

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			joy_word  <= '0;
			use_port  <= 1'b0;
			osd_combo <= 1'b0;
		end else begin
			joy_word  <= joy_next;
			use_port  <= use_next;
			// Only a port in use may raise the OSD
			osd_combo <= use_next && combo_held;
		end
	end

endmodule

`default_nettype wire

//--- panel_encoder.sv
// Player slot routing and active-low panel encoding
// Standard and twin-stick layouts, merged pause and OSD button
`timescale 1ns/1ns
`default_nettype none

module panel_encoder (
	input  logic                                clk_sys,
	input  logic                                iRST,
	input  sys1_input_pkg::joy_word_u           port_joy [sys1_input_pkg::num_ports],
	input  logic [sys1_input_pkg::num_ports-1:0] port_use,
	input  logic [sys1_input_pkg::num_ports-1:0] port_combo,
	input  logic [sys1_input_pkg::joy_w-1:0]    usb_joy1,
	input  logic [sys1_input_pkg::joy_w-1:0]    usb_joy2,
	input  logic                                twin_mode,
	output logic [7:0]                          inp0,
	output logic [7:0]                          inp1,
	output logic [7:0]                          inp2,
	output logic                                pause_btn,
	output logic                                osd_button
);

	sys1_input_pkg::joy_word_u slot1;
	sys1_input_pkg::joy_word_u slot2;
	sys1_input_pkg::joy_word_u merged;
	logic [7:0] stick_byte;
	logic [7:0] sys_byte;
	logic       r_up;
	logic       r_down;
	logic       r_left;
	logic       r_right;

	////////////////////////////////////////////////////////////
	// Slot routing
	////////////////////////////////////////////////////////////
	// Port 0 is player 1, port 1 is player 2
	// USB pads shift over into whatever slot is left free
	always_comb begin
		case (port_use)
			2'b11: begin
				slot1 = port_joy[0];
				slot2 = port_joy[1];
			end
			2'b01: begin
				slot1 = port_joy[0];
				slot2 = usb_joy1;
			end
			2'b10: begin
				slot1 = usb_joy1;
				slot2 = port_joy[1];
			end
			default: begin
				slot1 = usb_joy1;
				slot2 = usb_joy2;
			end
		endcase
	end

	assign merged = slot1 | slot2;

	// Right stick also takes player 2's left stick
	assign r_up    = slot1.twin.r_up    | slot2.twin.l_up;
	assign r_down  = slot1.twin.r_down  | slot2.twin.l_down;
	assign r_left  = slot1.twin.r_left  | slot2.twin.l_left;
	assign r_right = slot1.twin.r_right | slot2.twin.l_right;

	////////////////////////////////////////////////////////////
	// Panel bytes, active high here and inverted at the register
	////////////////////////////////////////////////////////////
	always_comb begin
		if (twin_mode) begin
			stick_byte = {slot1.twin.l_left, slot1.twin.l_right,
				slot1.twin.l_up, slot1.twin.l_down,
				r_left, r_right, r_up, r_down};
			sys_byte   = {slot1.twin.fire, slot1.twin.fire,
				merged.stnd.start2, merged.stnd.start1, 3'b000, merged.stnd.coin};
		end else begin
			// Trigger order on the board is 2, 1, 3
			stick_byte = {merged.stnd.left, merged.stnd.right,
				merged.stnd.up, merged.stnd.down, 1'b0,
				merged.stnd.trig[2], merged.stnd.trig[1], merged.stnd.trig[3]};
			sys_byte   = {2'b00, merged.stnd.start2, merged.stnd.start1,
				3'b000, merged.stnd.coin};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			inp0       <= 8'hFF;
			inp1       <= 8'hFF;
			inp2       <= 8'hFF;
			pause_btn  <= 1'b0;
			osd_button <= 1'b0;
		end else begin
			// Both player banks read the same stick byte
			inp0       <= ~stick_byte;
			inp1       <= ~stick_byte;
			inp2       <= ~sys_byte;
			pause_btn  <= merged.stnd.pause;
			osd_button <= |port_combo;
		end
	end

endmodule

`default_nettype wire

//--- pause_control.sv
// Pause control
// User pause toggle, pause while OSD is open and dim-video timer
`timescale 1ns/1ns
`default_nettype none

module pause_control #(
	parameter int unsigned dim_cycles = sys1_input_pkg::dim_cycles_default
) (
	input  logic clk_sys,
	input  logic iRST,
	input  logic pause_btn,
	input  logic osd_status,
	input  logic osd_pause_off,
	output logic pause,
	output logic dim_video
);

	localparam int unsigned cnt_w = (dim_cycles > 1) ? $clog2(dim_cycles + 1) : 1;

	logic             btn_prev;
	logic             toggle;
	logic             toggle_next;
	logic [cnt_w-1:0] pause_cnt;

	// Flip on the press edge only
	assign toggle_next = toggle ^ (pause_btn && !btn_prev);

	always_ff @(posedge clk_sys) begin
		if (iRST) begin
			btn_prev  <= 1'b0;
			toggle    <= 1'b0;
			pause_cnt <= '0;
		end else begin
			btn_prev <= pause_btn;
			toggle   <= toggle_next;
			// Counter follows the new toggle so dim drops with pause
			if (!toggle_next)
				pause_cnt <= '0;
			else if (pause_cnt != cnt_w'(dim_cycles))
				pause_cnt <= pause_cnt + 1'b1;
		end
	end

	// OSD pause unless the menu option turns it off
	assign pause     = toggle || (osd_status && !osd_pause_off);
	assign dim_video = (pause_cnt == cnt_w'(dim_cycles));

endmodule

`default_nettype wire

//--- sys1_input_top.sv
// Arcade input subsystem top level
// Config download, two low-latency ports, panel encoding and pause
`timescale 1ns/1ns
`default_nettype none

module sys1_input_top #(
	parameter int unsigned dim_cycles = sys1_input_pkg::dim_cycles_default
) (
	input  logic                                     clk_sys,
	input  logic                                     iRST,
	input  logic                                     ioctl_wr,
	input  logic [7:0]                               ioctl_index,
	input  logic [24:0]                              ioctl_addr,
	input  logic [7:0]                               ioctl_dout,
	input  logic                                     llapi_select,
	input  logic                                     osd_status,
	input  logic                                     osd_pause_off,
	input  logic [sys1_input_pkg::joy_w-1:0]         usb_joy1,
	input  logic [sys1_input_pkg::joy_w-1:0]         usb_joy2,
	input  logic [sys1_input_pkg::llapi_btn_w-1:0]   llapi_buttons_a,
	input  logic [sys1_input_pkg::llapi_btn_w-1:0]   llapi_buttons_b,
	input  logic [sys1_input_pkg::llapi_type_w-1:0]  llapi_type_a,
	input  logic [sys1_input_pkg::llapi_type_w-1:0]  llapi_type_b,
	input  logic                                     llapi_en_a,
	input  logic                                     llapi_en_b,
	output logic [7:0]                               sysmode,
	output logic [7:0]                               dsw0,
	output logic [7:0]                               dsw1,
	output logic [7:0]                               inp0,
	output logic [7:0]                               inp1,
	output logic [7:0]                               inp2,
	output logic                                     osd_button,
	output logic                                     pause,
	output logic                                     dim_video
);

	logic                                    llapi_on;
	logic                                    pause_btn;
	logic [sys1_input_pkg::llapi_btn_w-1:0]  port_buttons [sys1_input_pkg::num_ports];
	logic [sys1_input_pkg::llapi_type_w-1:0] port_type [sys1_input_pkg::num_ports];
	logic [sys1_input_pkg::num_ports-1:0]    port_en;
	sys1_input_pkg::joy_word_u               port_joy [sys1_input_pkg::num_ports];
	logic [sys1_input_pkg::num_ports-1:0]    port_use;
	logic [sys1_input_pkg::num_ports-1:0]    port_combo;

	// Port A is player 1, port B is player 2
	assign port_buttons[0] = llapi_buttons_a;
	assign port_buttons[1] = llapi_buttons_b;
	assign port_type[0]    = llapi_type_a;
	assign port_type[1]    = llapi_type_b;
	assign port_en         = {llapi_en_b, llapi_en_a};

	sys_config u_config (
		.clk_sys      (clk_sys),
		.iRST         (iRST),
		.ioctl_wr     (ioctl_wr),
		.ioctl_index  (ioctl_index),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.llapi_select (llapi_select),
		.sysmode      (sysmode),
		.dsw0         (dsw0),
		.dsw1         (dsw1),
		.llapi_on     (llapi_on)
	);

	for (genvar i = 0; i < sys1_input_pkg::num_ports; i++) begin : g_port
		llapi_port_map u_port (
			.clk_sys   (clk_sys),
			.iRST      (iRST),
			.llapi_on  (llapi_on),
			.buttons   (port_buttons[i]),
			.ctrl_type (port_type[i]),
			.ctrl_en   (port_en[i]),
			.joy_word  (port_joy[i]),
			.use_port  (port_use[i]),
			.osd_combo (port_combo[i])
		);
	end

	panel_encoder u_encoder (
		.clk_sys    (clk_sys),
		.iRST       (iRST),
		.port_joy   (port_joy),
		.port_use   (port_use),
		.port_combo (port_combo),
		.usb_joy1   (usb_joy1),
		.usb_joy2   (usb_joy2),
		.twin_mode  (sysmode[sys1_input_pkg::sysmode_twin_bit]),
		.inp0       (inp0),
		.inp1       (inp1),
		.inp2       (inp2),
		.pause_btn  (pause_btn),
		.osd_button (osd_button)
	);

	pause_control #(
		.dim_cycles (dim_cycles)
	) u_pause (
		.clk_sys       (clk_sys),
		.iRST          (iRST),
		.pause_btn     (pause_btn),
		.osd_status    (osd_status),
		.osd_pause_off (osd_pause_off),
		.pause         (pause),
		.dim_video     (dim_video)
	);

endmodule

`default_nettype wire

//--- sys1_input_chk.sv
// Input subsystem assertion checker
// Bound to the top level, watches pause, reset values and OSD button
`timescale 1ns/1ns
`default_nettype none

module sys1_input_chk (
	input logic       clk_sys,
	input logic       iRST,
	input logic [7:0] inp0,
	input logic [7:0] inp1,
	input logic [7:0] inp2,
	input logic       osd_button,
	input logic       pause,
	input logic       dim_video,
	input logic [1:0] port_use
);

	// Assertion failures so far
	int unsigned fail_count = 0;

	// Dimming only ever happens during a pause
	a_dim_needs_pause : assert property (@(posedge clk_sys) disable iff (iRST)
		dim_video |-> pause)
		else begin
			$error("dim_video set while not paused");
			fail_count++;
		end

	// Idle panel right after reset
	a_reset_idle : assert property (@(posedge clk_sys)
		$fell(iRST) |-> (inp0 == 8'hFF) && (inp1 == 8'hFF) && (inp2 == 8'hFF)
			&& !pause && !dim_video && !osd_button)
		else begin
			$error("outputs not idle after reset");
			fail_count++;
		end

	// OSD combo needs a port in use
	a_osd_needs_port : assert property (@(posedge clk_sys) disable iff (iRST)
		osd_button |-> (port_use != 2'b00))
		else begin
			$error("osd_button set with no port in use");
			fail_count++;
		end

endmodule

bind sys1_input_top sys1_input_chk u_chk (.*);

`default_nettype wire

//--- tb_sys1_scoreboard.sv
// Testbench scoreboard
// Compares DUT outputs with the expected row values and counts mismatches
`timescale 1ns/1ns
`default_nettype none

module tb_sys1_scoreboard (
	input  logic       clk_sys,
	input  logic       check_en,
	input  int         row_idx,
	input  logic [7:0] exp_sysmode,
	input  logic [7:0] exp_dsw0,
	input  logic [7:0] exp_dsw1,
	input  logic [7:0] exp_inp0,
	input  logic [7:0] exp_inp2,
	input  logic       exp_osd,
	input  logic       exp_pause,
	input  logic       exp_dim,
	input  logic [7:0] sysmode,
	input  logic [7:0] dsw0,
	input  logic [7:0] dsw1,
	input  logic [7:0] inp0,
	input  logic [7:0] inp1,
	input  logic [7:0] inp2,
	input  logic       osd_button,
	input  logic       pause,
	input  logic       dim_video,
	output int         err_count
);

	initial err_count = 0;

	task automatic compare(input string name, input logic [7:0] expv, input logic [7:0] got);
		if (got !== expv) begin
			$display("[FAIL] row %0d %s expected 0x%02h got 0x%02h", row_idx, name, expv, got);
			err_count = err_count + 1;
		end
	endtask

	// Strobe is set one clock early, so outputs here are settled
	always @(posedge clk_sys) begin
		if (check_en) begin
			compare("sysmode", exp_sysmode, sysmode);
			compare("dsw0", exp_dsw0, dsw0);
			compare("dsw1", exp_dsw1, dsw1);
			compare("inp0", exp_inp0, inp0);
			compare("inp1", exp_inp0, inp1);
			compare("inp2", exp_inp2, inp2);
			compare("osd_button", {7'd0, exp_osd}, {7'd0, osd_button});
			compare("pause", {7'd0, exp_pause}, {7'd0, pause});
			compare("dim_video", {7'd0, exp_dim}, {7'd0, dim_video});
		end
	end

endmodule

`default_nettype wire

//--- tb_sys1_input.sv
// Input subsystem testbench
// Table-driven config, routing, encoding, OSD combo and pause checks
`timescale 1ns/1ns
`default_nettype none

module tb_sys1_input;

	typedef struct packed {
		logic        wr;
		logic [7:0]  idx;
		logic [7:0]  addr;
		logic [7:0]  dat;
		logic [15:0] usb1;
		logic [15:0] usb2;
		logic [31:0] btn_a;
		logic [31:0] btn_b;
		logic [7:0]  typ_a;
		logic [7:0]  typ_b;
		logic        en_a;
		logic        en_b;
		logic        sel;
		logic        osd;
		logic        poff;
		logic        rnd;
		logic [7:0]  e_sys;
		logic [7:0]  e_d0;
		logic [7:0]  e_d1;
		logic [7:0]  e_in0;
		logic [7:0]  e_in2;
		logic        e_osd;
		logic        e_pause;
		logic        e_dim;
	} row_t;

	// Button bits outside every mapping
	localparam logic [31:0] unused_mask = ~32'h0F00_007F;

	logic clk_sys;
	logic iRST;
	logic ioctl_wr, llapi_select, osd_status, osd_pause_off, llapi_en_a, llapi_en_b;
	logic [7:0] ioctl_index, ioctl_dout, llapi_type_a, llapi_type_b;
	logic [24:0] ioctl_addr;
	logic [15:0] usb_joy1, usb_joy2;
	logic [31:0] llapi_buttons_a, llapi_buttons_b;
	logic [7:0] sysmode, dsw0, dsw1, inp0, inp1, inp2;
	logic osd_button, pause, dim_video;
	logic check_en;
	int row_idx;
	int err_count;
	int timeouts;
	row_t cur;
	row_t tbl [$];

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	sys1_input_top #(.dim_cycles(20)) UUT (.*);

	tb_sys1_scoreboard u_scoreboard (
		.clk_sys(clk_sys), .check_en(check_en), .row_idx(row_idx),
		.exp_sysmode(cur.e_sys), .exp_dsw0(cur.e_d0), .exp_dsw1(cur.e_d1),
		.exp_inp0(cur.e_in0), .exp_inp2(cur.e_in2), .exp_osd(cur.e_osd),
		.exp_pause(cur.e_pause), .exp_dim(cur.e_dim),
		.sysmode(sysmode), .dsw0(dsw0), .dsw1(dsw1), .inp0(inp0), .inp1(inp1),
		.inp2(inp2), .osd_button(osd_button), .pause(pause), .dim_video(dim_video),
		.err_count(err_count)
	);

	task automatic load_table();
		// Config download, bit 5 of sysmode has no effect
		tbl.push_back(row_t'{1,1,0,'h20, 0,0, 0,0, 0,0, 0,0,0,0,0,0, 'h20,0,0,'hFF,'hFF,0,0,0});
		tbl.push_back(row_t'{1,254,0,'hA5, 0,0, 0,0, 0,0, 0,0,0,0,0,0, 'h20,'hA5,0,'hFF,'hFF,0,0,0});
		tbl.push_back(row_t'{1,254,1,'h3C, 0,0, 0,0, 0,0, 0,0,0,0,0,0,
			'h20,'hA5,'h3C,'hFF,'hFF,0,0,0});
		tbl.push_back(row_t'{1,254,2,'hFF, 0,0, 0,0, 0,0, 0,0,0,0,0,0,
			'h20,'hA5,'h3C,'hFF,'hFF,0,0,0});
		tbl.push_back(row_t'{1,2,0,'h77, 0,0, 0,0, 0,0, 0,0,0,0,0,0,
			'h20,'hA5,'h3C,'hFF,'hFF,0,0,0});
		// USB only, merged standard bytes
		tbl.push_back(row_t'{0,0,0,0, 'h0011,'h0828, 0,0, 0,0, 0,0,0,0,0,0,
			'h20,'hA5,'h3C,'h99,'hFE,0,0,0});
		tbl.push_back(row_t'{0,0,0,0, 'h0246,'h0400, 0,0, 0,0, 0,0,0,0,0,0,
			'h20,'hA5,'h3C,'h6E,'hCF,0,0,0});
		// Type 0 and 255 without presses leave USB in both slots
		tbl.push_back(row_t'{0,0,0,0, 'h0001,'h0008, 0,0, 'h00,'hFF, 1,1,1,0,0,0,
			'h20,'hA5,'h3C,'h9F,'hFF,0,0,0});
		// Valid type alone claims port 0 and USB 1 moves to slot 2
		tbl.push_back(row_t'{0,0,0,0, 'h0001,'h0008, 0,0, 'h05,'hFF, 1,1,1,0,0,0,
			'h20,'hA5,'h3C,'hBF,'hFF,0,0,0});
		// Press claims port 1 alone, USB 1 stays in slot 1
		tbl.push_back(row_t'{0,0,0,0, 'h0004,'h0008, 0,'h0000_0001, 'h00,'hFF, 0,1,1,0,0,1,
			'h20,'hA5,'h3C,'hED,'hFF,0,0,0});
		tbl.push_back(row_t'{0,0,0,0, 'h0002,0, 'h0800_0010,'h0100_0002, 'h00,'hFF, 1,1,1,0,0,1,
			'h20,'hA5,'h3C,'h9B,'hFE,0,0,0});
		// Twin stick
		tbl.push_back(row_t'{1,1,0,'h08, 0,0, 'h0200_0044,'h0800_0020, 0,'hFF, 1,1,1,0,0,0,
			'h08,'hA5,'h3C,'h7C,'h2F,0,0,0});
		// OSD combo on port 0 then port 1
		tbl.push_back(row_t'{0,0,0,0, 0,0, 'h0400_0021,0, 0,'hFF, 1,1,1,0,0,0,
			'h08,'hA5,'h3C,'hEB,'hEF,1,0,0});
		tbl.push_back(row_t'{1,1,0,'h00, 0,0, 0,'h0400_0021, 0,'hFF, 1,1,1,0,0,0,
			'h00,'hA5,'h3C,'hED,'hEF,1,0,0});
		// Released pads keep their slots and USB stays out
		tbl.push_back(row_t'{0,0,0,0, 'h0001,'h0008, 0,0, 0,'hFF, 1,1,1,0,0,0,
			'h00,'hA5,'h3C,'hFF,'hFF,0,0,0});
		tbl.push_back(row_t'{0,0,0,0, 0,0, 0,0, 0,0, 0,0,0,0,0,0, 'h00,'hA5,'h3C,'hFF,'hFF,0,0,0});
		// Pause press, release, then wait out the dim timer
		tbl.push_back(row_t'{0,0,0,0, 'h1000,0, 0,0, 0,0, 0,0,0,0,0,0,
			'h00,'hA5,'h3C,'hFF,'hFF,0,1,0});
		repeat (4)
			tbl.push_back(row_t'{0,0,0,0, 0,0, 0,0, 0,0, 0,0,0,0,0,0,
				'h00,'hA5,'h3C,'hFF,'hFF,0,1,0});
		tbl.push_back(row_t'{0,0,0,0, 0,0, 0,0, 0,0, 0,0,0,0,0,0, 'h00,'hA5,'h3C,'hFF,'hFF,0,1,1});
		// Second press releases pause and dim
		tbl.push_back(row_t'{0,0,0,0, 'h1000,0, 0,0, 0,0, 0,0,0,0,0,0,
			'h00,'hA5,'h3C,'hFF,'hFF,0,0,0});
		// OSD open pauses unless turned off
		tbl.push_back(row_t'{0,0,0,0, 0,0, 0,0, 0,0, 0,0,0,1,0,0, 'h00,'hA5,'h3C,'hFF,'hFF,0,1,0});
		tbl.push_back(row_t'{0,0,0,0, 0,0, 0,0, 0,0, 0,0,0,1,1,0, 'h00,'hA5,'h3C,'hFF,'hFF,0,0,0});
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] fill_a;
		logic [31:0] fill_b;
		fill_a = r.rnd ? ($urandom & unused_mask) : 32'd0;
		fill_b = r.rnd ? ($urandom & unused_mask) : 32'd0;
		ioctl_wr        <= r.wr;
		ioctl_index     <= r.idx;
		ioctl_addr      <= {17'd0, r.addr};
		ioctl_dout      <= r.dat;
		usb_joy1        <= r.usb1;
		usb_joy2        <= r.usb2;
		llapi_buttons_a <= r.btn_a | fill_a;
		llapi_buttons_b <= r.btn_b | fill_b;
		llapi_type_a    <= r.typ_a;
		llapi_type_b    <= r.typ_b;
		llapi_en_a      <= r.en_a;
		llapi_en_b      <= r.en_b;
		llapi_select    <= r.sel;
		osd_status      <= r.osd;
		osd_pause_off   <= r.poff;
	endtask

	// Idle panel after reset, bounded
	task automatic wait_idle();
		int n;
		n = 0;
		while ((inp0 !== 8'hFF) && (n < 20)) begin
			@(posedge clk_sys);
			n = n + 1;
		end
		if (n >= 20) begin
			$display("Timed out waiting for the idle panel after reset");
			timeouts = timeouts + 1;
		end
	endtask

	initial begin
		void'($urandom(20));
		timeouts = 0;
		row_idx = 0;
		check_en = 1'b0;
		cur = '0;
		iRST = 1'b1;
		apply_row('0);
		load_table();
		repeat (10) @(posedge clk_sys);
		iRST <= 1'b0;
		@(posedge clk_sys);
		wait_idle();
		foreach (tbl[i]) begin
			apply_row(tbl[i]);
			repeat (3) @(posedge clk_sys);
			row_idx  <= i;
			cur      <= tbl[i];
			check_en <= 1'b1;
			@(posedge clk_sys);
			check_en <= 1'b0;
		end
		@(posedge clk_sys);
		$display("Rows %0d, value errors %0d, assertion errors %0d, timeouts %0d",
			tbl.size(), err_count, UUT.u_chk.fail_count, timeouts);
		if ((err_count == 0) && (UUT.u_chk.fail_count == 0) && (timeouts == 0))
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
sys1_input_pkg.sv
sys_config.sv
llapi_port_map.sv
panel_encoder.sv
pause_control.sv
sys1_input_top.sv
sys1_input_chk.sv
tb_sys1_scoreboard.sv
tb_sys1_input.sv
